// File: source/audio_pkg.sv
package audio_pkg;

	////////////////////////////////////////////////////////////
	// Avalon bus master
	////////////////////////////////////////////////////////////
	localparam int addr_width = 32;
	localparam int data_width = 32;

	// Audio core register map, base 0x3040
	localparam logic [addr_width-1:0] audio_fifo_addr = 32'h0000_3044;
	localparam logic [addr_width-1:0] audio_left_addr = 32'h0000_3048;
	localparam logic [addr_width-1:0] audio_right_addr = 32'h0000_304c;

	localparam logic [3:0] byte_enable_all = 4'b1111;

	// Free words sit in the top byte of the FIFO-space register
	localparam int fifo_space_msb = 31;
	localparam int fifo_space_lsb = 24;
	localparam int fifo_space_width = 8;
	localparam logic [fifo_space_width-1:0] fifo_min_space = 8'd2;

	////////////////////////////////////////////////////////////
	// Synthesizer
	////////////////////////////////////////////////////////////
	localparam int phase_width = 32;
	localparam int rom_addr_width = 8;
	localparam int tune_width = 10;
	localparam int tune_shift = 16;
	localparam int sample_width = 16;
	localparam int quarter_depth = 65;
	localparam int sample_shift = 16;

	typedef enum logic [2:0] {
		issue_read,
		wait_read,
		decide,
		wait_left,
		issue_right,
		wait_right
	} master_state_t;

endpackage

// File: source/sine_rom.sv
`timescale 1ns/100ps

module sine_rom (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic [audio_pkg::rom_addr_width-1:0] phase_index,
	output logic signed [audio_pkg::sample_width-1:0] sample
);

	// First quadrant only, 0 up to and including the peak
	logic [audio_pkg::sample_width-1:0] quarter [0:audio_pkg::quarter_depth-1];

	logic [audio_pkg::rom_addr_width-2:0] half_index;
	logic [audio_pkg::rom_addr_width-2:0] fold_index;
	logic signed [audio_pkg::sample_width-1:0] magnitude;
	logic negative_half;

	initial begin
		$readmemh("source/sine_quarter.hex", quarter);
	end

	////////////////////////////////////////////////////////////
	// Quadrant folding
	////////////////////////////////////////////////////////////

	// Position inside the current half cycle
	assign half_index = phase_index[audio_pkg::rom_addr_width-2:0];
	assign negative_half = phase_index[audio_pkg::rom_addr_width-1];

	// Second quadrant walks back down from the peak.
	// 128 minus the index wraps to the 7-bit negation, 64 stays 64
	always_comb begin
		if (phase_index[audio_pkg::rom_addr_width-2]) begin
			fold_index = -half_index;
		end else begin
			fold_index = half_index;
		end
	end

	assign magnitude = quarter[fold_index];

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	// Negate over the back half of the cycle
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			sample <= '0;
		end else if (negative_half) begin
			sample <= -magnitude;
		end else begin
			sample <= magnitude;
		end
	end

	// Both zero crossings, index 0 and 128, give exactly zero
	a_zero_crossing: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		(half_index == '0) |=> (sample == '0)
	) else $error("sine_rom: sample at a zero crossing is not zero");

endmodule

// File: source/dds_synth.sv
`timescale 1ns/100ps

module dds_synth (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic [audio_pkg::tune_width-1:0] tune,
	input  logic advance,
	output logic signed [audio_pkg::sample_width-1:0] sample,
	output logic sample_valid
);

	localparam int pad_width = audio_pkg::phase_width - audio_pkg::tune_width
		- audio_pkg::tune_shift;

	logic [audio_pkg::phase_width-1:0] phase;
	logic [audio_pkg::phase_width-1:0] phase_step;
	logic [1:0] settle;

	// Switch value lands at bit 16 of the increment
	assign phase_step = {{pad_width{1'b0}}, tune, {audio_pkg::tune_shift{1'b0}}};

	////////////////////////////////////////////////////////////
	// Phase accumulator and settle tracking
	////////////////////////////////////////////////////////////

	// One edge for the ROM, one more before the sample is flagged valid
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
			settle <= 2'b00;
		end else if (advance) begin
			phase <= phase + phase_step;
			settle <= 2'b00;
		end else begin
			settle <= {settle[0], 1'b1};
		end
	end

	assign sample_valid = settle[1];

	sine_rom i_sine_rom (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.phase_index (phase[audio_pkg::phase_width-1 -: audio_pkg::rom_addr_width]),
		.sample      (sample)
	);

	// The bus master must wait for a settled sample before stepping
	a_advance_when_valid: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		advance |-> sample_valid
	) else $error("dds_synth: advance arrived before the sample settled");

endmodule

// File: source/audio_bus_master.sv
`timescale 1ns/100ps

module audio_bus_master (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic signed [audio_pkg::sample_width-1:0] sample,
	input  logic sample_valid,
	output logic advance,
	output logic [audio_pkg::addr_width-1:0] bus_addr,
	output logic [3:0] bus_byte_enable,
	output logic bus_read,
	output logic bus_write,
	output logic [audio_pkg::data_width-1:0] bus_write_data,
	input  logic bus_ack,
	input  logic [audio_pkg::data_width-1:0] bus_read_data,
	output logic [audio_pkg::fifo_space_width-1:0] fifo_space
);

	audio_pkg::master_state_t state;

	logic room;
	logic [audio_pkg::data_width-1:0] sample_word;

	assign room = fifo_space > audio_pkg::fifo_min_space;

	// Sample in the upper half of the word, lower half zero
	assign sample_word = {sample, {audio_pkg::sample_shift{1'b0}}};

	// Synthesizer steps on the same edge the left write goes out
	assign advance = (state == audio_pkg::decide) && room && sample_valid;

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= audio_pkg::issue_read;
			bus_read <= 1'b0;
			bus_write <= 1'b0;
			fifo_space <= '0;
		end else begin
			case (state)
				audio_pkg::issue_read: begin
					bus_read <= 1'b1;
					state <= audio_pkg::wait_read;
				end
				audio_pkg::wait_read: begin
					if (bus_ack) begin
						bus_read <= 1'b0;
						fifo_space <= bus_read_data[audio_pkg::fifo_space_msb:
							audio_pkg::fifo_space_lsb];
						state <= audio_pkg::decide;
					end
				end
				audio_pkg::decide: begin
					// No room so poll again straight away
					if (!room) begin
						bus_read <= 1'b1;
						state <= audio_pkg::wait_read;
					end else if (sample_valid) begin
						bus_write <= 1'b1;
						state <= audio_pkg::wait_left;
					end
				end
				audio_pkg::wait_left: begin
					if (bus_ack) begin
						bus_write <= 1'b0;
						state <= audio_pkg::issue_right;
					end
				end
				audio_pkg::issue_right: begin
					bus_write <= 1'b1;
					state <= audio_pkg::wait_right;
				end
				audio_pkg::wait_right: begin
					if (bus_ack) begin
						bus_write <= 1'b0;
						state <= audio_pkg::issue_read;
					end
				end
				default: begin
					bus_read <= 1'b0;
					bus_write <= 1'b0;
					state <= audio_pkg::issue_read;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Address and data
	////////////////////////////////////////////////////////////

	// Loaded only where a request starts, held otherwise
	always_ff @(posedge CLOCK_50) begin
		case (state)
			audio_pkg::issue_read: begin
				bus_addr <= audio_pkg::audio_fifo_addr;
				bus_byte_enable <= audio_pkg::byte_enable_all;
			end
			audio_pkg::decide: begin
				if (!room) begin
					bus_addr <= audio_pkg::audio_fifo_addr;
					bus_byte_enable <= audio_pkg::byte_enable_all;
				end else if (sample_valid) begin
					bus_addr <= audio_pkg::audio_left_addr;
					bus_byte_enable <= audio_pkg::byte_enable_all;
					bus_write_data <= sample_word;
				end
			end
			// Right channel reuses the left word
			audio_pkg::issue_right: begin
				bus_addr <= audio_pkg::audio_right_addr;
				bus_byte_enable <= audio_pkg::byte_enable_all;
			end
			default: begin
			end
		endcase
	end

	a_one_direction: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		!(bus_read && bus_write)
	) else $error("audio_bus_master: read and write requested together");

	// Request, address and data wait for the acknowledge
	a_request_held: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		(bus_read || bus_write) && !bus_ack |=>
			(bus_read || bus_write) && $stable(bus_addr)
	) else $error("audio_bus_master: request or address moved before acknowledge");

	a_write_data_held: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		bus_write && !bus_ack |=> bus_write && $stable(bus_write_data)
	) else $error("audio_bus_master: write data moved before acknowledge");

endmodule

// File: source/audio_dds_top.sv
`timescale 1ns/100ps

module audio_dds_top (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic [audio_pkg::tune_width-1:0] sw,
	output logic [9:0] ledr,
	output logic [audio_pkg::addr_width-1:0] bus_addr,
	output logic [3:0] bus_byte_enable,
	output logic bus_read,
	output logic bus_write,
	output logic [audio_pkg::data_width-1:0] bus_write_data,
	input  logic bus_ack,
	input  logic [audio_pkg::data_width-1:0] bus_read_data
);

	logic signed [audio_pkg::sample_width-1:0] sample;
	logic sample_valid;
	logic advance;
	logic [audio_pkg::fifo_space_width-1:0] fifo_space;

	////////////////////////////////////////////////////////////
	// Tone source
	////////////////////////////////////////////////////////////

	dds_synth i_dds_synth (
		.CLOCK_50     (CLOCK_50),
		.rst_n        (rst_n),
		.tune         (sw),
		.advance      (advance),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	////////////////////////////////////////////////////////////
	// Audio core bus master
	////////////////////////////////////////////////////////////

	audio_bus_master i_audio_bus_master (
		.CLOCK_50        (CLOCK_50),
		.rst_n           (rst_n),
		.sample          (sample),
		.sample_valid    (sample_valid),
		.advance         (advance),
		.bus_addr        (bus_addr),
		.bus_byte_enable (bus_byte_enable),
		.bus_read        (bus_read),
		.bus_write       (bus_write),
		.bus_write_data  (bus_write_data),
		.bus_ack         (bus_ack),
		.bus_read_data   (bus_read_data),
		.fifo_space      (fifo_space)
	);

	// Last FIFO space read, on the low LEDs
	assign ledr = {{($bits(ledr) - audio_pkg::fifo_space_width){1'b0}}, fifo_space};

endmodule

// File: bench/audio_core_model.sv
`timescale 1ns/100ps

module audio_core_model (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic [audio_pkg::addr_width-1:0] bus_addr,
	input  logic bus_read,
	input  logic bus_write,
	input  logic [audio_pkg::data_width-1:0] bus_write_data,
	output logic bus_ack,
	output logic [audio_pkg::data_width-1:0] bus_read_data,
	output logic log_write,
	output logic [audio_pkg::addr_width-1:0] log_addr,
	output logic [audio_pkg::data_width-1:0] log_data
);

	integer seed;
	int delay_left;
	int read_count;
	logic busy;

	// Mostly plenty of room, with short runs of a nearly full FIFO
	function automatic logic [7:0] scripted_space(input int index);
		case (index % 16)
			5, 6: scripted_space = 8'd0;
			10: scripted_space = 8'd1;
			11, 12, 13: scripted_space = 8'd2;
			default: scripted_space = 8'd64;
		endcase
	endfunction

	initial begin
		seed = 32'hfbd2;
		busy = 1'b0;
		delay_left = 0;
		read_count = 0;
		bus_ack = 1'b0;
		bus_read_data = '0;
		log_write = 1'b0;
		log_addr = '0;
		log_data = '0;
	end

	////////////////////////////////////////////////////////////
	// Slave response, 1 ns after each rising edge
	////////////////////////////////////////////////////////////

	always @(posedge CLOCK_50) begin
		#1;
		log_write = 1'b0;
		if (!rst_n) begin
			bus_ack = 1'b0;
			busy = 1'b0;
		end else if (bus_ack) begin
			// Master drops the request on this edge
			bus_ack = 1'b0;
			busy = 1'b0;
		end else if (bus_read || bus_write) begin
			if (!busy) begin
				busy = 1'b1;
				delay_left = $random(seed) & 3;
			end
			if (delay_left == 0) begin
				bus_ack = 1'b1;
				if (bus_read) begin
					// Junk below the top byte, only the space count matters
					bus_read_data = {scripted_space(read_count), 8'h00, read_count[15:0]};
					read_count = read_count + 1;
				end else begin
					log_write = 1'b1;
					log_addr = bus_addr;
					log_data = bus_write_data;
				end
			end else begin
				delay_left = delay_left - 1;
			end
		end
	end

endmodule

// File: bench/tb_audio_dds.sv
`timescale 1ns/100ps

module tb_audio_dds;

	localparam int num_pairs = 300;
	localparam int cycles_per_pair = 40;
	localparam int timeout_cycles = num_pairs * cycles_per_pair;
	localparam real pi = 3.14159265358979;

	typedef enum {kind_none, kind_read, kind_left, kind_right} request_kind_t;

	logic CLOCK_50;
	logic rst_n;
	logic [audio_pkg::tune_width-1:0] sw;
	logic [9:0] ledr;
	logic [audio_pkg::addr_width-1:0] bus_addr;
	logic [3:0] bus_byte_enable;
	logic bus_read;
	logic bus_write;
	logic [audio_pkg::data_width-1:0] bus_write_data;
	logic bus_ack;
	logic [audio_pkg::data_width-1:0] bus_read_data;
	logic log_write;
	logic [audio_pkg::addr_width-1:0] log_addr;
	logic [audio_pkg::data_width-1:0] log_data;

	integer seed = 32'hfbd2;
	int cycle_count = 0;
	int pairs_done = 0;
	int value_errors = 0;
	int order_errors = 0;
	int protocol_errors = 0;
	logic first_after_reset = 1'b0;
	logic space_known = 1'b0;
	logic [audio_pkg::fifo_space_width-1:0] last_space = '0;
	logic [audio_pkg::phase_width-1:0] ref_phase = '0;
	logic [audio_pkg::data_width-1:0] left_word = '0;
	request_kind_t last_kind = kind_none;

	audio_dds_top i_audio_dds_top (
		.CLOCK_50        (CLOCK_50),
		.rst_n           (rst_n),
		.sw              (sw),
		.ledr            (ledr),
		.bus_addr        (bus_addr),
		.bus_byte_enable (bus_byte_enable),
		.bus_read        (bus_read),
		.bus_write       (bus_write),
		.bus_write_data  (bus_write_data),
		.bus_ack         (bus_ack),
		.bus_read_data   (bus_read_data)
	);

	audio_core_model i_audio_core_model (
		.CLOCK_50        (CLOCK_50),
		.rst_n           (rst_n),
		.bus_addr        (bus_addr),
		.bus_read        (bus_read),
		.bus_write       (bus_write),
		.bus_write_data  (bus_write_data),
		.bus_ack         (bus_ack),
		.bus_read_data   (bus_read_data),
		.log_write       (log_write),
		.log_addr        (log_addr),
		.log_data        (log_data)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #5 CLOCK_50 = ~CLOCK_50;
	end

	always @(posedge CLOCK_50) begin
		cycle_count <= cycle_count + 1;
	end

	// Nearest integer to 16383 sin(2 pi p / 256)
	function automatic int expected_sample(input logic [7:0] p);
		real value;
		value = 16383.0 * $sin(2.0 * pi * p / 256.0);
		if (value < 0.0) begin
			expected_sample = -$rtoi(0.5 - value);
		end else begin
			expected_sample = $rtoi(value + 0.5);
		end
	endfunction

	task automatic finish_run(input bit timed_out);
		$display("Errors: value %0d, order %0d, protocol %0d after %0d pairs in %0d cycles",
			value_errors, order_errors, protocol_errors, pairs_done, cycle_count);
		if (!timed_out && value_errors == 0 && order_errors == 0 && protocol_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		int rand_word;
		int i;
		rst_n = 1'b0;
		rand_word = $random(seed);
		sw = rand_word[9:0];
		repeat (2) @(posedge CLOCK_50);
		#1 rst_n = 1'b1;
		// New tuning word only between a right acknowledge and the next left write
		for (i = 0; i < num_pairs; i++) begin
			wait (pairs_done > i);
			@(posedge CLOCK_50);
			#1;
			rand_word = $random(seed);
			sw = rand_word[9:0];
		end
		repeat (4) @(posedge CLOCK_50);
		finish_run(1'b0);
	end

	initial begin
		audio_pkg::master_state_t stuck_state;
		wait (cycle_count >= timeout_cycles);
		stuck_state = i_audio_dds_top.i_audio_bus_master.state;
		$display("Timeout: only %0d of %0d sample pairs written, bus master in state %s",
			pairs_done, num_pairs, stuck_state.name());
		finish_run(1'b1);
	end

	////////////////////////////////////////////////////////////
	// Monitor, sampled on the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge CLOCK_50) begin
		int expected;
		int actual;
		int diff;
		logic [audio_pkg::data_width-1:0] expected_word;
		if (!rst_n || first_after_reset) begin
			assert (!bus_read && !bus_write && ledr == 10'd0) else begin
				value_errors++;
				$display("ERROR reset_state: expected read 0 write 0 ledr 000, actual %b %b %h",
					bus_read, bus_write, ledr);
			end
		end else begin
			if (space_known) begin
				assert (ledr == {2'b00, last_space}) else begin
					value_errors++;
					$display("ERROR fifo_led: expected %h actual %h", {2'b00, last_space}, ledr);
				end
			end
			if (bus_read && bus_ack) begin
				assert (bus_addr == audio_pkg::audio_fifo_addr && bus_byte_enable == 4'hf)
				else begin
					order_errors++;
					$display("Read went to address %h with byte enables %b", bus_addr,
						bus_byte_enable);
				end
				assert (last_kind != kind_left) else begin
					order_errors++;
					$display("Left write was not followed by a right write");
				end
				assert (!(last_kind == kind_read && last_space > 8'd2)) else begin
					order_errors++;
					$display("Read reported room for %0d words but no write pair followed",
						last_space);
				end
				last_space = bus_read_data[31:24];
				space_known = 1'b1;
				last_kind = kind_read;
			end
			if (log_write && log_addr == audio_pkg::audio_left_addr) begin
				assert (last_kind == kind_read && last_space > 8'd2) else begin
					order_errors++;
					$display("Left write without a read that reported room");
				end
				expected = expected_sample(ref_phase[31:24]);
				actual = {{16{log_data[31]}}, log_data[31:16]};
				diff = (actual > expected) ? actual - expected : expected - actual;
				expected_word = {expected[15:0], 16'h0000};
				assert (diff <= 1 && log_data[15:0] == 16'h0000) else begin
					value_errors++;
					$display("ERROR sample_value: expected %h actual %h", expected_word, log_data);
				end
				left_word = log_data;
				ref_phase = ref_phase + {6'b000000, sw, 16'h0000};
				last_kind = kind_left;
			end else if (log_write && log_addr == audio_pkg::audio_right_addr) begin
				assert (last_kind == kind_left) else begin
					order_errors++;
					$display("Right write without a left write just before it");
				end
				assert (log_data == left_word) else begin
					value_errors++;
					$display("ERROR right_word: expected %h actual %h", left_word, log_data);
				end
				last_kind = kind_right;
				pairs_done++;
			end else if (log_write) begin
				order_errors++;
				$display("Write to an unexpected address %h", log_addr);
			end
		end
		first_after_reset = !rst_n;
	end

	////////////////////////////////////////////////////////////
	// Bus protocol
	////////////////////////////////////////////////////////////

	a_single_direction: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		!(bus_read && bus_write)
	) else begin
		protocol_errors++;
		$display("Bus read and write were high together at %0t", $time);
	end

	a_request_holds: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		(bus_read || bus_write) && !bus_ack |=> $stable(bus_read) && $stable(bus_write)
			&& $stable(bus_addr) && $stable(bus_byte_enable)
	) else begin
		protocol_errors++;
		$display("Request or address changed before the acknowledge at %0t", $time);
	end

	a_write_data_holds: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		bus_write && !bus_ack |=> $stable(bus_write_data)
	) else begin
		protocol_errors++;
		$display("Write data changed before the acknowledge at %0t", $time);
	end

endmodule

// File: source/sine_quarter.hex
0000
0192
0324
04B5
0646
07D5
0964
0AF1
0C7C
0E06
0F8D
1112
1294
1413
158F
1708
187E
19EF
1B5D
1CC6
1E2B
1F8B
20E7
223D
238E
24D9
261F
275F
2899
29CD
2AFA
2C21
2D41
2E59
2F6B
3075
3178
3273
3367
3452
3536
3611
36E4
37AF
3871
392A
39DA
3A81
3B20
3BB5
3C41
3CC4
3D3E
3DAE
3E14
3E71
3EC4
3F0E
3F4E
3F84
3FB0
3FD3
3FEB
3FFA
3FFF

// File: all.f
source/audio_pkg.sv
source/sine_rom.sv
source/dds_synth.sv
source/audio_bus_master.sv
source/audio_dds_top.sv
bench/audio_core_model.sv
bench/tb_audio_dds.sv

// File: Makefile
VERILATOR ?= verilator
TOP       = tb_audio_dds
FILELIST  = all.f
SIMFLAGS  = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
